// File: verilog.f
common/display_pkg.sv
common/draw_pkg.sv
common/draw_if.sv
rtl/display_timing.sv
draw/shape_sequencer.sv
draw/draw_rectangle.sv
framebuffer/framebuffer.sv
rtl/rect_draw_top.sv
tb/rect_draw_chk.sv
tb/tb_rect_draw.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the rectangle drawing testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_rect_draw
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    echo "simulation passed, log in $LOG"
    exit 0
else
    echo "pass message missing from $LOG"
    exit 1
fi

// File: tb/tb_rect_draw.sv
// Directed testbench for the rectangle drawing top level.
// Scans the pixel stream frame by frame and compares it with a painted reference image.
`timescale 1ns/1ns
`default_nettype none

module tb_rect_draw;
    import display_pkg::*;
    import draw_pkg::*;

    localparam int RESET_CYC    = 10;
    localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;  // 4160 clocks
    localparam int TIMEOUT_CYC  = 60 * FRAME_CYC;  // drawing takes about 9 frames
    localparam int SCAN_BLANK   = 0;  // every pixel 0
    localparam int SCAN_FULL    = 1;  // final colour only

    logic  clk_100m;
    logic  rst;
    cidx_t pix_cidx;
    logic  hsync_o, vsync_o, de_o, all_done;

    cidx_t ref_img [FB_HEIGHT][FB_WIDTH];  // expected final image
    int    outline_pix;  // outline pixels over all rectangles
    int    cycles = 0;
    int    reset_cyc;  // cycle count at reset release

    rect_draw_top dut (
        .clk_100m (clk_100m),
        .rst      (rst),
        .pix_cidx (pix_cidx),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .de_o     (de_o),
        .all_done (all_done)
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;  // 100 MHz
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk_100m) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            abort_run($sformatf("timeout after %0d cycles, the run did not finish", cycles));
        end
    end

    task automatic paint(input int x, input int y, input cidx_t c);
        if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT) begin
            ref_img[y][x] = c;  // clipped like the framebuffer
        end
    endtask

    // rectangles 0 to 7 painted in order, later ones on top
    task automatic build_reference();
        int    x0, y0, x1, y1;
        cidx_t c;
        outline_pix = 0;
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) begin
                ref_img[y][x] = '0;
            end
        end
        for (int i = 0; i < SHAPE_CNT; i++) begin
            x0 = RECT_X0 + i * RECT_STEP;
            y0 = RECT_Y0 + i * RECT_STEP;
            x1 = RECT_X1 - i * RECT_STEP;
            y1 = RECT_Y1 - i * RECT_STEP;
            c  = cidx_t'((i % 16) + 1);  // never background
            for (int x = x0; x <= x1; x++) begin
                paint(x, y0, c);
                paint(x, y1, c);
            end
            for (int y = y0; y <= y1; y++) begin
                paint(x0, y, c);
                paint(x1, y, c);
            end
            outline_pix += 2 * (x1 - x0 + 1) + 2 * (y1 - y0 + 1) - 4;  // corners once
        end
    endtask

    // leaves the caller on the first visible pixel of the next frame
    task automatic wait_frame_start();
        while (!vsync_o) @(negedge clk_100m);
        while (vsync_o) @(negedge clk_100m);
        while (!de_o) @(negedge clk_100m);
    endtask

    task automatic scan_frame(input string name, input int mode);
        cidx_t want;
        for (int y = 0; y < FB_HEIGHT; y++) begin
            while (!de_o) @(negedge clk_100m);  // blanking
            for (int x = 0; x < FB_WIDTH; x++) begin
                want = (mode == SCAN_BLANK) ? cidx_t'(0) : ref_img[y][x];
                assert (de_o) else abort_run($sformatf("%s: de dropped inside line %0d", name, y));
                assert (pix_cidx == want) else abort_run($sformatf(
                    "MISMATCH %s pixel (%0d,%0d) expected %0d actual %0d",
                    name, x, y, want, pix_cidx));
                assert (all_done == (mode == SCAN_FULL)) else abort_run($sformatf(
                    "%s: all_done is %0b at pixel (%0d,%0d)", name, all_done, x, y));
                @(negedge clk_100m);
            end
            assert (!de_o) else abort_run($sformatf("%s: line %0d longer than 64", name, y));
        end
    endtask

    task automatic test_reset();
        assert (!all_done) else abort_run("reset: all_done high right after reset");
        scan_frame("reset", SCAN_BLANK);  // frame 0 starts at reset release
    endtask

    // frames 1 up to FRAME_WAIT-1 still blank
    task automatic test_start_delay();
        for (int f = 1; f < FRAME_WAIT; f++) begin
            wait_frame_start();
            scan_frame("start_delay", SCAN_BLANK);
        end
    endtask

    task automatic test_raster();
        int         sx_e, sy_e, de_line, de_lines;
        logic [2:0] want, got;  // hsync, vsync, de
        de_line  = 0;
        de_lines = 0;
        wait_frame_start();
        for (int t = 0; t <= FRAME_CYC; t++) begin
            sx_e    = (t % FRAME_CYC) % H_TOTAL;  // last step wraps to the next frame
            sy_e    = (t % FRAME_CYC) / H_TOTAL;
            want[2] = (sx_e >= H_SYNC_START) && (sx_e < H_SYNC_END);
            want[1] = (sy_e >= V_SYNC_START) && (sy_e < V_SYNC_END);
            want[0] = (sx_e < FB_WIDTH) && (sy_e < FB_HEIGHT);
            got     = {hsync_o, vsync_o, de_o};
            assert (got == want) else abort_run($sformatf(
                "MISMATCH raster at (%0d,%0d) expected %b actual %b", sx_e, sy_e, want, got));
            de_line += int'(de_o);
            if (sx_e == H_TOTAL - 1) begin
                assert (de_line == 0 || de_line == FB_WIDTH) else abort_run($sformatf(
                    "MISMATCH raster de per line expected %0d actual %0d", FB_WIDTH, de_line));
                if (de_line > 0) begin
                    de_lines++;
                end
                de_line = 0;
            end
            @(negedge clk_100m);
        end
        assert (de_lines == FB_HEIGHT) else abort_run($sformatf(
            "MISMATCH raster visible lines expected %0d actual %0d", FB_HEIGHT, de_lines));
    endtask

    task automatic test_pacing();
        int need, elapsed, min_cyc, max_cyc;
        need    = (outline_pix + PIX_FRAME - 1) / PIX_FRAME;  // budget frames
        min_cyc = (FRAME_WAIT + need - 1) * FRAME_CYC;  // last budget frame opens here
        max_cyc = (FRAME_WAIT + need + 1) * FRAME_CYC;  // spare frame, budget runs between shapes
        while (!all_done) @(negedge clk_100m);
        elapsed = cycles - reset_cyc;
        assert (elapsed >= min_cyc && elapsed <= max_cyc) else abort_run($sformatf(
            "MISMATCH pacing all_done cycle expected %0d..%0d actual %0d",
            min_cyc, max_cyc, elapsed));
    endtask

    task automatic test_final_image();
        wait_frame_start();
        scan_frame("final_image", SCAN_FULL);
    endtask

    task automatic test_stability();
        wait_frame_start();
        scan_frame("stability", SCAN_FULL);  // nothing written after the last done
    endtask

    initial begin
        rst = 1'b1;
        build_reference();
        repeat (RESET_CYC) @(negedge clk_100m);
        rst       = 1'b0;
        reset_cyc = cycles;
        test_reset();
        test_start_delay();
        test_raster();
        test_pacing();
        test_final_image();
        test_stability();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/rect_draw_chk.sv
// Protocol checks on the rectangle drawer, bound into every draw_rectangle.
`timescale 1ns/1ns
`default_nettype none

module rect_draw_chk (
    input wire logic             clk_100m,
    input wire logic             rst,
    input wire logic             start,
    input wire logic             drawing,
    input wire logic             done,
    input wire logic             oe,
    input wire draw_pkg::coord_t x,  // drawer position
    input wire draw_pkg::coord_t y
);
    logic busy;  // between start and done

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    drawing_needs_start: assert property (@(posedge clk_100m) disable iff (rst)
        drawing |-> busy) else $error("drawing raised without a start");

    done_one_cycle: assert property (@(posedge clk_100m) disable iff (rst)
        done |=> !done) else $error("done held longer than one cycle");

    hold_without_oe: assert property (@(posedge clk_100m) disable iff (rst)
        (busy && !oe) |=> ($stable(x) && $stable(y)))
        else $error("drawer moved while oe was low");

endmodule

bind draw_rectangle rect_draw_chk chk (
    .clk_100m (clk_100m),
    .rst      (rst),
    .start    (shp.start),
    .drawing  (shp.drawing),
    .done     (shp.done),
    .oe       (shp.oe),
    .x        (x),
    .y        (y)
);

`default_nettype wire

// File: rtl/rect_draw_top.sv
// Top level of the rectangle drawing demo on one clock.
// Raster timing, shape sequencer, drawer and framebuffer, raw colour index out.
`timescale 1ns/1ns
`default_nettype none

module rect_draw_top (
    input  wire logic       clk_100m,
    input  wire logic       rst,
    output draw_pkg::cidx_t pix_cidx,  // colour index per pixel
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            de_o,
    output logic            all_done  // every rectangle drawn
);
    import display_pkg::*;

    raster_t sx, sy;  // raster position
    logic    hsync, vsync, de, frame;

    shape_if shp ();
    pixel_if pix ();

    display_timing display_timing_inst (
        .clk_100m (clk_100m),
        .rst      (rst),
        .sx       (sx),
        .sy       (sy),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .frame    (frame)
    );

    shape_sequencer shape_sequencer_inst (
        .clk_100m (clk_100m),
        .rst      (rst),
        .frame    (frame),
        .shp      (shp),
        .all_done (all_done)
    );

    draw_rectangle draw_rectangle_inst (
        .clk_100m (clk_100m),
        .rst      (rst),
        .shp      (shp),
        .pix      (pix)
    );

    framebuffer framebuffer_inst (
        .clk_100m (clk_100m),
        .rst      (rst),
        .pix      (pix),
        .sx       (sx),
        .sy       (sy),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .pix_cidx (pix_cidx),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .de_o     (de_o)
    );

endmodule

`default_nettype wire

// File: framebuffer/framebuffer.sv
// Colour index framebuffer with separate write and read ports.
// Writes come from the drawer, reads follow the raster with one cycle latency.
`timescale 1ns/1ns
`default_nettype none

module framebuffer (
    input  wire logic             clk_100m,
    input  wire logic             rst,
    pixel_if.sink                 pix,
    input  wire display_pkg::raster_t sx,
    input  wire display_pkg::raster_t sy,
    input  wire logic             hsync,
    input  wire logic             vsync,
    input  wire logic             de,
    output draw_pkg::cidx_t       pix_cidx,  // 0 outside de
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o
);
    import display_pkg::*;
    import draw_pkg::*;

    cidx_t    mem [FB_DEPTH];
    cidx_t    rd_data;
    fb_addr_t wr_addr, rd_addr;
    logic     in_fb;  // write lands on screen

    initial begin
        for (int i = 0; i < FB_DEPTH; i++) mem[i] = '0;  // blank at power up
    end

    always_comb begin
        in_fb   = (pix.x >= coord_t'(0)) && (pix.x < coord_t'(FB_WIDTH))
                  && (pix.y >= coord_t'(0)) && (pix.y < coord_t'(FB_HEIGHT));
        wr_addr = fb_addr_t'(int'(pix.y) * FB_WIDTH + int'(pix.x));
        rd_addr = fb_addr_t'(int'(sy) * FB_WIDTH + int'(sx));
    end

    // write port, clipped
    always_ff @(posedge clk_100m) begin
        if (pix.we && in_fb) mem[wr_addr] <= pix.cidx;
    end

    // read port, only inside the visible area
    always_ff @(posedge clk_100m) begin
        if (de) rd_data <= mem[rd_addr];
    end

    // match sync and de to the read latency
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            hsync_o <= hsync;
            vsync_o <= vsync;
            de_o    <= de;
        end
    end

    always_comb pix_cidx = de_o ? rd_data : '0;

endmodule

`default_nettype wire

// File: draw/draw_rectangle.sv
// Walks the outline of one rectangle, one pixel per cycle with oe high.
// Order is top, bottom, left then right edge, corners may be hit twice.
`timescale 1ns/1ns
`default_nettype none

module draw_rectangle (
    input  wire logic clk_100m,
    input  wire logic rst,
    shape_if.exec     shp,
    pixel_if.src      pix
);
    import draw_pkg::*;

    typedef enum logic [2:0] {IDLE, TOP, BOTTOM, LEFT, RIGHT} state_t;

    state_t state;
    coord_t x0, y0, x1, y1;  // corners latched on start
    coord_t x, y;  // current pixel
    cidx_t  cidx;
    logic   end_x, end_y;  // reached far end of edge

    always_comb begin
        end_x = (x == x1);
        end_y = (y == y1);
    end

    // control
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state    <= IDLE;
            shp.done <= 1'b0;
        end else begin
            shp.done <= 1'b0;
            case (state)
                IDLE:    if (shp.start) state <= TOP;
                TOP:     if (shp.oe && end_x) state <= BOTTOM;
                BOTTOM:  if (shp.oe && end_x) state <= LEFT;
                LEFT:    if (shp.oe && end_y) state <= RIGHT;
                RIGHT: begin
                    if (shp.oe && end_y) begin
                        state    <= IDLE;
                        shp.done <= 1'b1;  // last pixel written this cycle
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // datapath, position only moves on oe
    always_ff @(posedge clk_100m) begin
        if (state == IDLE) begin
            if (shp.start) begin
                x0   <= shp.x0;
                y0   <= shp.y0;
                x1   <= shp.x1;
                y1   <= shp.y1;
                cidx <= shp.cidx;
                x    <= shp.x0;  // top left first
                y    <= shp.y0;
            end
        end else if (shp.oe) begin
            case (state)
                TOP: begin
                    if (end_x) begin
                        x <= x0;  // jump to bottom left
                        y <= y1;
                    end else begin
                        x <= x + coord_t'(1);
                    end
                end
                BOTTOM: begin
                    if (end_x) begin
                        x <= x0;  // back to top left
                        y <= y0;
                    end else begin
                        x <= x + coord_t'(1);
                    end
                end
                LEFT: begin
                    if (end_y) begin
                        x <= x1;  // top right
                        y <= y0;
                    end else begin
                        y <= y + coord_t'(1);
                    end
                end
                RIGHT:   if (!end_y) y <= y + coord_t'(1);
                default: x <= x;
            endcase
        end
    end

    always_comb begin
        shp.drawing = (state != IDLE) && shp.oe;
        pix.we      = shp.drawing;
        pix.x       = x;
        pix.y       = y;
        pix.cidx    = cidx;
    end

endmodule

`default_nettype wire

// File: draw/shape_sequencer.sv
// Steps through the rectangle run and decodes each shape's corners and colour.
// Also meters drawing with the frame wait and the per-frame pixel budget.
`timescale 1ns/1ns
`default_nettype none

module shape_sequencer (
    input  wire logic clk_100m,
    input  wire logic rst,
    input  wire logic frame,  // start of frame from raster
    shape_if.issue    shp,
    output logic      all_done  // level, whole run finished
);
    import draw_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;

    state_t    state;
    shape_id_t shape_id;  // current rectangle
    wait_cnt_t cnt_wait;  // frames passed, saturating
    pix_cnt_t  cnt_pix;  // enabled cycles this frame
    logic      wait_over;
    logic      last_shape;

    always_comb last_shape = (shape_id == shape_id_t'(SHAPE_CNT - 1));

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state    <= IDLE;
            shape_id <= '0;
        end else begin
            case (state)
                IDLE: if (frame) state <= INIT;  // first shape on first frame
                INIT: state <= DRAW;  // start goes out here
                DRAW: begin
                    if (shp.done) begin
                        if (last_shape) begin
                            state <= DONE;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= INIT;
                        end
                    end
                end
                default: state <= DONE;  // stays until reset
            endcase
        end
    end

    // decode, stable while shape_id holds
    always_comb begin
        shp.start = (state == INIT);
        shp.x0    = coord_t'(RECT_X0 + RECT_STEP * int'(shape_id));
        shp.y0    = coord_t'(RECT_Y0 + RECT_STEP * int'(shape_id));
        shp.x1    = coord_t'(RECT_X1 - RECT_STEP * int'(shape_id));
        shp.y1    = coord_t'(RECT_Y1 - RECT_STEP * int'(shape_id));
        shp.cidx  = cidx_t'(shape_id) + cidx_t'(1);  // skip background 0
        all_done  = (state == DONE);
    end

    // pacing: frame wait then a budget of enabled cycles per frame
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            cnt_wait <= '0;
            cnt_pix  <= '0;
        end else if (frame) begin
            cnt_pix <= shp.oe ? pix_cnt_t'(1) : '0;  // frame cycle is in the new frame
            if (!wait_over && state != IDLE) begin
                cnt_wait <= cnt_wait + 1'b1;  // pulse after frame 0 began ends a frame
            end
        end else if (shp.oe) begin
            cnt_pix <= cnt_pix + 1'b1;
        end
    end

    always_comb begin
        wait_over = (cnt_wait == wait_cnt_t'(FRAME_WAIT));
        shp.oe    = wait_over && (cnt_pix != pix_cnt_t'(PIX_FRAME));
    end

endmodule

`default_nettype wire

// File: rtl/display_timing.sv
// Raster counters for the 80x52 timing, visible area in the top left 64x48.
// Sync, de and frame are decoded straight from the counters.
`timescale 1ns/1ns
`default_nettype none

module display_timing (
    input  wire logic        clk_100m,
    input  wire logic        rst,
    output display_pkg::raster_t sx,  // horizontal position
    output display_pkg::raster_t sy,  // vertical position
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output logic             frame
);
    import display_pkg::*;

    logic last_x, last_y;  // end of line / end of frame

    always_comb begin
        last_x = (sx == raster_t'(H_TOTAL - 1));
        last_y = (sy == raster_t'(V_TOTAL - 1));
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (last_x) begin
            sx <= '0;  // wrap to next line
            sy <= last_y ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync windows are half open, high from START up to END
    always_comb begin
        hsync = (sx >= raster_t'(H_SYNC_START)) && (sx < raster_t'(H_SYNC_END));
        vsync = (sy >= raster_t'(V_SYNC_START)) && (sy < raster_t'(V_SYNC_END));
        de    = (sx < raster_t'(FB_WIDTH)) && (sy < raster_t'(FB_HEIGHT));
        frame = (sx == '0) && (sy == '0);  // origin, once per frame
    end

endmodule

`default_nettype wire

// File: common/draw_if.sv
// Shape command and pixel write interfaces inside the drawing path.
// shape_if runs sequencer to drawer, pixel_if runs drawer to framebuffer.
`timescale 1ns/1ns
`default_nettype none

interface shape_if;
    import draw_pkg::*;

    logic   start;  // one-cycle pulse, drawer idle
    coord_t x0, y0, x1, y1;  // corners, stable start..done
    cidx_t  cidx;  // outline colour
    logic   oe;  // level, drawer may advance
    logic   drawing;  // pixel valid this cycle
    logic   done;  // one-cycle pulse after last pixel

    modport issue (output start, x0, y0, x1, y1, cidx, oe, input drawing, done);
    modport exec  (input start, x0, y0, x1, y1, cidx, oe, output drawing, done);
endinterface

interface pixel_if;
    import draw_pkg::*;

    coord_t x, y;  // unclipped pixel position
    cidx_t  cidx;
    logic   we;  // write strobe

    modport src  (output x, y, cidx, we);
    modport sink (input x, y, cidx, we);
endinterface

`default_nettype wire

// File: common/draw_pkg.sv
// Drawing types, the rectangle rule and the pacing constants.
// Imported by the shape interfaces, the sequencer, the drawer and the framebuffer.
`default_nettype none

package draw_pkg;

    localparam int CORDW = 16;  // drawing coordinate width

    typedef logic signed [CORDW-1:0] coord_t;  // may go off screen
    typedef logic [3:0] cidx_t;  // colour index, 0 is background

    // shape run
    localparam int SHAPE_CNT = 8;
    typedef logic [$clog2(SHAPE_CNT)-1:0] shape_id_t;

    // rectangle i spans (X0+i*STEP, Y0+i*STEP) to (X1-i*STEP, Y1-i*STEP)
    localparam int RECT_X0   = 8;
    localparam int RECT_Y0   = 4;
    localparam int RECT_X1   = 55;
    localparam int RECT_Y1   = 43;
    localparam int RECT_STEP = 1;  // shrink per shape on each side

    // pacing
    localparam int FRAME_WAIT = 2;  // frames before drawing starts
    localparam int PIX_FRAME  = 200;  // enabled cycles per frame

    typedef logic [$clog2(FRAME_WAIT+1)-1:0] wait_cnt_t;  // saturates at FRAME_WAIT
    typedef logic [$clog2(PIX_FRAME+1)-1:0] pix_cnt_t;  // stops at PIX_FRAME

endpackage

`default_nettype wire

// File: common/display_pkg.sv
// Raster timing and framebuffer geometry for the reduced display.
// Imported by the timing generator, the framebuffer and the top level.
`default_nettype none

package display_pkg;

    // visible area, also the framebuffer size
    localparam int FB_WIDTH  = 64;
    localparam int FB_HEIGHT = 48;

    // horizontal timing in clocks
    localparam int H_TOTAL      = 80;
    localparam int H_SYNC_START = 68;  // first clock of hsync
    localparam int H_SYNC_END   = 75;  // first clock after hsync

    // vertical timing in lines
    localparam int V_TOTAL      = 52;
    localparam int V_SYNC_START = 49;  // first line of vsync
    localparam int V_SYNC_END   = 50;  // first line after vsync

    // framebuffer memory geometry
    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW = $clog2(FB_DEPTH);

    // raster counter wide enough for the longer axis
    localparam int RASTER_W = $clog2(H_TOTAL);

    typedef logic [RASTER_W-1:0] raster_t;  // screen position, unsigned
    typedef logic [FB_ADDRW-1:0] fb_addr_t;  // framebuffer word address

endpackage

`default_nettype wire
